/* project.f */
source/trig_pkg.sv
source/trig_cfg_if.sv
source/trig_req_if.sv
source/trig_ctrl_regs.sv
source/trig_capture.sv
source/trig_phase_out.sv
source/trig_ctrl_top.sv
test/tb_clkgen.sv
test/tb_trig_ctrl.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_trig_ctrl -f project.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; [ -f sim.log ] && ! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* source/trig_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_capture #(
    parameter int ADDR_W = 12
) (
    input  wire              sysclk_i,
    input  wire              arst_n_i,
    input  wire [ADDR_W-1:0] cur_addr_i,
    input  wire              pps_trig_i,
    input  wire [5:0]        gp_in_i,
    trig_cfg_if.capture      cfg,
    trig_req_if.capture      req
);

    // two sync stages plus the previous value for edge detection
    logic [2:0] pps_sh;
    // select flop, then two sync stages, the top one doubles as the edge flop
    logic [2:0] ext_sh;
    logic [7:0] ext_vec;
    logic       pps_edge_q, ext_edge_q;

    logic [trig_pkg::NUM_SRC-1:0]             fire;
    logic [trig_pkg::NUM_SRC-1:0][ADDR_W-1:0] src_ofs;
    logic [trig_pkg::NUM_SRC-1:0]             req_q;
    logic [trig_pkg::NUM_SRC-1:0][ADDR_W-1:0] addr_q;

    // selects 0 and 7 map to constant zero and can never fire
    assign ext_vec = {1'b0, gp_in_i, 1'b0};

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pps_sh     <= '0;
            ext_sh     <= '0;
            pps_edge_q <= 1'b0;
            ext_edge_q <= 1'b0;
        end else begin
            pps_sh     <= {pps_sh[1:0], pps_trig_i};
            ext_sh     <= {ext_sh[1:0], ext_vec[cfg.ext_sel]};
            // edges that arrive while a request is pending are dropped
            pps_edge_q <= pps_sh[1] & ~pps_sh[2] & cfg.pps_en & ~req_q[trig_pkg::SRC_PPS];
            ext_edge_q <= ext_sh[1] & ~ext_sh[2] & cfg.ext_en & ~req_q[trig_pkg::SRC_EXT];
        end
    end

    always_comb begin
        fire[trig_pkg::SRC_SOFT]    = cfg.soft_fire & ~req_q[trig_pkg::SRC_SOFT];
        fire[trig_pkg::SRC_PPS]     = pps_edge_q;
        fire[trig_pkg::SRC_EXT]     = ext_edge_q;
        // soft triggers are untimed, so no offset
        src_ofs[trig_pkg::SRC_SOFT] = '0;
        src_ofs[trig_pkg::SRC_PPS]  = cfg.pps_offset;
        src_ofs[trig_pkg::SRC_EXT]  = cfg.ext_offset;
    end

    // a request stays pending until the next window capture point
    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
        end else begin
            for (int i = 0; i < trig_pkg::NUM_SRC; i++) begin
                if (fire[i]) begin
                    req_q[i] <= 1'b1;
                end else if (req.win_open) begin
                    req_q[i] <= 1'b0;
                end
            end
        end
    end

    // address wraps modulo the sample buffer size
    always_ff @(posedge sysclk_i) begin
        for (int i = 0; i < trig_pkg::NUM_SRC; i++) begin
            if (fire[i]) begin
                addr_q[i] <= cur_addr_i - src_ofs[i];
            end
        end
    end

    assign req.req  = req_q;
    assign req.addr = addr_q;

endmodule

`default_nettype wire

/* source/trig_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// trigger configuration from the register bank to the capture block
interface trig_cfg_if #(
    parameter int ADDR_W = 12
);

    logic              pps_en;
    // offsets are already reduced to the sample address width
    logic [ADDR_W-1:0] pps_offset;
    logic              ext_en;
    logic [2:0]        ext_sel;
    logic [ADDR_W-1:0] ext_offset;
    // single clock pulse per soft trigger write
    logic              soft_fire;

    modport regs (
        output pps_en,
        output pps_offset,
        output ext_en,
        output ext_sel,
        output ext_offset,
        output soft_fire
    );

    modport capture (
        input pps_en,
        input pps_offset,
        input ext_en,
        input ext_sel,
        input ext_offset,
        input soft_fire
    );

endinterface

`default_nettype wire

/* source/trig_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_ctrl_regs #(
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_LATENCY = '0,
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_OFFSET  = '0,
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_HOLDOFF = '0
) (
    input  wire                          sysclk_i,
    input  wire                          arst_n_i,
    input  wire                          reg_stb_i,
    input  wire                          reg_we_i,
    input  wire  [3:0]                   reg_sel_i,
    input  wire  [7:0]                   reg_adr_i,
    input  wire  [31:0]                  reg_wdat_i,
    input  wire                          running_i,
    input  wire                          event_i,
    output logic [31:0]                  reg_rdat_o,
    output logic                         reg_ack_o,
    output logic [trig_pkg::MASK_W-1:0]  trig_mask_o,
    output logic                         mask_update_o,
    output logic [trig_pkg::CFG_W-1:0]   trig_latency_o,
    output logic [trig_pkg::CFG_W-1:0]   trig_offset_o,
    output logic [trig_pkg::CFG_W-1:0]   trig_holdoff_o,
    trig_cfg_if.regs                     cfg
);

    logic [trig_pkg::MASK_W-1:0] mask_q;
    logic [trig_pkg::CFG_W-1:0]  lat_q, ofs_q, hold_q;
    logic [trig_pkg::CFG_W-1:0]  pps_ofs_q, ext_ofs_q;
    logic                        pps_en_q, ext_en_q;
    logic [2:0]                  ext_sel_q;
    logic [1:0]                  run_q;
    logic [31:0]                 ev_cnt_q;
    logic                        ack_q, mask_upd_q, soft_q;
    logic [31:0]                 cur_word, wr_word;
    logic                        wr_en;

    assign wr_en = reg_stb_i & reg_we_i;

    // current contents of the addressed register
    always_comb begin
        case (trig_pkg::reg_addr_e'(reg_adr_i))
            trig_pkg::ADDR_MASK:    cur_word = {4'h0, mask_q};
            trig_pkg::ADDR_LAT_OFS: cur_word = {ofs_q, lat_q};
            trig_pkg::ADDR_PPS:     cur_word = {pps_ofs_q, 15'h0, pps_en_q};
            trig_pkg::ADDR_EXT:     cur_word = {ext_ofs_q, 5'h0, ext_sel_q, 7'h0, ext_en_q};
            trig_pkg::ADDR_SOFT:    cur_word = {15'h0, run_q[1], 16'h0};
            trig_pkg::ADDR_HOLDOFF: cur_word = {16'h0, hold_q};
            trig_pkg::ADDR_EVCOUNT: cur_word = ev_cnt_q;
            default:                cur_word = '0;
        endcase
    end

    // byte lanes not selected keep their old value
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wr_word[8*i +: 8] = reg_sel_i[i] ? reg_wdat_i[8*i +: 8] : cur_word[8*i +: 8];
        end
    end

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q    <= '1;
            lat_q     <= DEFAULT_LATENCY;
            ofs_q     <= DEFAULT_OFFSET;
            hold_q    <= DEFAULT_HOLDOFF;
            pps_en_q  <= 1'b0;
            pps_ofs_q <= '0;
            ext_en_q  <= 1'b0;
            ext_sel_q <= '0;
            ext_ofs_q <= '0;
        end else if (wr_en) begin
            case (trig_pkg::reg_addr_e'(reg_adr_i))
                trig_pkg::ADDR_MASK: mask_q <= wr_word[trig_pkg::MASK_W-1:0];
                trig_pkg::ADDR_LAT_OFS: begin
                    lat_q <= wr_word[15:0];
                    ofs_q <= wr_word[31:16];
                end
                trig_pkg::ADDR_PPS: begin
                    pps_en_q  <= wr_word[0];
                    pps_ofs_q <= wr_word[31:16];
                end
                trig_pkg::ADDR_EXT: begin
                    ext_en_q  <= wr_word[0];
                    ext_sel_q <= wr_word[10:8];
                    ext_ofs_q <= wr_word[31:16];
                end
                trig_pkg::ADDR_HOLDOFF: hold_q <= wr_word[15:0];
                default: ;
            endcase
        end
    end

    // bus handshake, update pulse and soft fire all line up with the ack
    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q      <= 1'b0;
            mask_upd_q <= 1'b0;
            soft_q     <= 1'b0;
            run_q      <= '0;
            ev_cnt_q   <= '0;
        end else begin
            ack_q      <= reg_stb_i;
            mask_upd_q <= wr_en && (reg_adr_i == trig_pkg::ADDR_MASK);
            soft_q     <= wr_en && (reg_adr_i == trig_pkg::ADDR_SOFT);
            run_q      <= {run_q[0], running_i};
            if (!run_q[1]) begin
                ev_cnt_q <= '0;
            end else if (event_i) begin
                ev_cnt_q <= ev_cnt_q + 32'd1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reg_stb_i && !reg_we_i) begin
            reg_rdat_o <= cur_word;
        end
    end

    assign reg_ack_o      = ack_q;
    assign mask_update_o  = mask_upd_q;
    assign trig_mask_o    = mask_q;
    assign trig_latency_o = lat_q;
    assign trig_offset_o  = ofs_q;
    assign trig_holdoff_o = hold_q;

    assign cfg.pps_en     = pps_en_q;
    assign cfg.pps_offset = pps_ofs_q[$bits(cfg.pps_offset)-1:0];
    assign cfg.ext_en     = ext_en_q;
    assign cfg.ext_sel    = ext_sel_q;
    assign cfg.ext_offset = ext_ofs_q[$bits(cfg.ext_offset)-1:0];
    assign cfg.soft_fire  = soft_q;

endmodule

`default_nettype wire

/* source/trig_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_ctrl_top #(
    parameter int                         ADDR_W          = 12,
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_LATENCY = '0,
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_OFFSET  = '0,
    parameter logic [trig_pkg::CFG_W-1:0] DEFAULT_HOLDOFF = '0
) (
    input  wire                         sysclk_i,
    input  wire                         arst_n_i,
    input  wire                         sysclk_phase_i,
    input  wire  [ADDR_W-1:0]           cur_addr_i,
    input  wire                         running_i,
    input  wire                         pps_trig_i,
    input  wire  [5:0]                  gp_in_i,
    input  wire                         event_i,
    // register bus
    input  wire                         reg_stb_i,
    input  wire                         reg_we_i,
    input  wire  [3:0]                  reg_sel_i,
    input  wire  [7:0]                  reg_adr_i,
    input  wire  [31:0]                 reg_wdat_i,
    output logic [31:0]                 reg_rdat_o,
    output logic                        reg_ack_o,
    // trigger streams
    output logic [ADDR_W-1:0]           soft_addr_o,
    output logic [7:0]                  soft_meta_o,
    output logic                        soft_valid_o,
    output logic [ADDR_W-1:0]           pps_addr_o,
    output logic [7:0]                  pps_meta_o,
    output logic                        pps_valid_o,
    output logic [ADDR_W-1:0]           ext_addr_o,
    output logic [7:0]                  ext_meta_o,
    output logic                        ext_valid_o,
    // settings for the downstream trigger logic
    output logic [trig_pkg::MASK_W-1:0] trig_mask_o,
    output logic                        mask_update_o,
    output logic [trig_pkg::CFG_W-1:0]  trig_latency_o,
    output logic [trig_pkg::CFG_W-1:0]  trig_offset_o,
    output logic [trig_pkg::CFG_W-1:0]  trig_holdoff_o
);

    trig_cfg_if #(.ADDR_W(ADDR_W)) cfg_if ();
    trig_req_if #(.ADDR_W(ADDR_W)) req_if ();

    trig_ctrl_regs #(
        .DEFAULT_LATENCY(DEFAULT_LATENCY),
        .DEFAULT_OFFSET (DEFAULT_OFFSET),
        .DEFAULT_HOLDOFF(DEFAULT_HOLDOFF)
    ) u_regs (
        .sysclk_i      (sysclk_i),
        .arst_n_i      (arst_n_i),
        .reg_stb_i     (reg_stb_i),
        .reg_we_i      (reg_we_i),
        .reg_sel_i     (reg_sel_i),
        .reg_adr_i     (reg_adr_i),
        .reg_wdat_i    (reg_wdat_i),
        .running_i     (running_i),
        .event_i       (event_i),
        .reg_rdat_o    (reg_rdat_o),
        .reg_ack_o     (reg_ack_o),
        .trig_mask_o   (trig_mask_o),
        .mask_update_o (mask_update_o),
        .trig_latency_o(trig_latency_o),
        .trig_offset_o (trig_offset_o),
        .trig_holdoff_o(trig_holdoff_o),
        .cfg           (cfg_if.regs)
    );

    trig_capture #(.ADDR_W(ADDR_W)) u_capture (
        .sysclk_i  (sysclk_i),
        .arst_n_i  (arst_n_i),
        .cur_addr_i(cur_addr_i),
        .pps_trig_i(pps_trig_i),
        .gp_in_i   (gp_in_i),
        .cfg       (cfg_if.capture),
        .req       (req_if.capture)
    );

    trig_phase_out #(.ADDR_W(ADDR_W)) u_phase_out (
        .sysclk_i      (sysclk_i),
        .arst_n_i      (arst_n_i),
        .sysclk_phase_i(sysclk_phase_i),
        .running_i     (running_i),
        .req           (req_if.phase),
        .soft_addr_o   (soft_addr_o),
        .soft_meta_o   (soft_meta_o),
        .soft_valid_o  (soft_valid_o),
        .pps_addr_o    (pps_addr_o),
        .pps_meta_o    (pps_meta_o),
        .pps_valid_o   (pps_valid_o),
        .ext_addr_o    (ext_addr_o),
        .ext_meta_o    (ext_meta_o),
        .ext_valid_o   (ext_valid_o)
    );

endmodule

`default_nettype wire

/* source/trig_phase_out.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_phase_out #(
    parameter int ADDR_W = 12
) (
    input  wire                sysclk_i,
    input  wire                arst_n_i,
    input  wire                sysclk_phase_i,
    input  wire                running_i,
    trig_req_if.phase          req,
    output logic [ADDR_W-1:0]  soft_addr_o,
    output logic [7:0]         soft_meta_o,
    output logic               soft_valid_o,
    output logic [ADDR_W-1:0]  pps_addr_o,
    output logic [7:0]         pps_meta_o,
    output logic               pps_valid_o,
    output logic [ADDR_W-1:0]  ext_addr_o,
    output logic [7:0]         ext_meta_o,
    output logic               ext_valid_o
);

    // phase strobe repeats every 8 clocks, bit 1 opens and bit 5 closes the window
    logic [5:0] phase_sh;

    logic [trig_pkg::NUM_SRC-1:0]             valid_q;
    logic [trig_pkg::NUM_SRC-1:0][7:0]        meta_q;
    logic [trig_pkg::NUM_SRC-1:0][ADDR_W-1:0] addr_q;

    assign req.win_open = phase_sh[1];

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_sh <= '0;
            valid_q  <= '0;
            meta_q   <= {trig_pkg::NUM_SRC{trig_pkg::META_RESET}};
        end else begin
            phase_sh <= {phase_sh[4:0], sysclk_phase_i};
            for (int i = 0; i < trig_pkg::NUM_SRC; i++) begin
                if (phase_sh[5]) begin
                    valid_q[i] <= 1'b0;
                end else if (phase_sh[1]) begin
                    valid_q[i] <= req.req[i];
                end
                // sequence count steps as each window closes
                if (!running_i) begin
                    meta_q[i] <= trig_pkg::META_RESET;
                end else if (valid_q[i] && phase_sh[5]) begin
                    meta_q[i][6:0] <= meta_q[i][6:0] + 7'd1;
                end
            end
        end
    end

    // hold the address steady for the whole window
    always_ff @(posedge sysclk_i) begin
        for (int i = 0; i < trig_pkg::NUM_SRC; i++) begin
            if (phase_sh[1] && req.req[i]) begin
                addr_q[i] <= req.addr[i];
            end
        end
    end

    assign soft_addr_o  = addr_q[trig_pkg::SRC_SOFT];
    assign soft_meta_o  = meta_q[trig_pkg::SRC_SOFT];
    assign soft_valid_o = valid_q[trig_pkg::SRC_SOFT];

    assign pps_addr_o   = addr_q[trig_pkg::SRC_PPS];
    assign pps_meta_o   = meta_q[trig_pkg::SRC_PPS];
    assign pps_valid_o  = valid_q[trig_pkg::SRC_PPS];

    assign ext_addr_o   = addr_q[trig_pkg::SRC_EXT];
    assign ext_meta_o   = meta_q[trig_pkg::SRC_EXT];
    assign ext_valid_o  = valid_q[trig_pkg::SRC_EXT];

endmodule

`default_nettype wire

/* source/trig_pkg.sv */
`default_nettype none

package trig_pkg;

    // register word addresses on the control bus, every register is 32 bits
    typedef enum logic [7:0] {
        ADDR_MASK    = 8'h00,
        ADDR_LAT_OFS = 8'h04,
        ADDR_PPS     = 8'h08,
        ADDR_EXT     = 8'h0C,
        ADDR_SOFT    = 8'h10,
        ADDR_HOLDOFF = 8'h18,
        ADDR_EVCOUNT = 8'h1C
    } reg_addr_e;

    // trigger sources, also the index into per-source arrays
    typedef enum logic [1:0] {
        SRC_SOFT = 2'd0,
        SRC_PPS  = 2'd1,
        SRC_EXT  = 2'd2
    } trig_src_e;

    localparam int NUM_SRC = 3;

    // top bit stays set, low 7 bits are the sequence count
    localparam logic [7:0] META_RESET = 8'h80;

    // trigger mask width
    localparam int MASK_W = 28;

    // latency, offset and holdoff word width
    localparam int CFG_W = 16;

endpackage

`default_nettype wire

/* source/trig_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// pending trigger requests from capture to the phase output stage
interface trig_req_if #(
    parameter int ADDR_W = 12
);

    // one pending flag and one captured address per source
    logic [trig_pkg::NUM_SRC-1:0]             req;
    logic [trig_pkg::NUM_SRC-1:0][ADDR_W-1:0] addr;
    // capture point of the output window, releases pending requests
    logic                                     win_open;

    modport capture (
        output req,
        output addr,
        input  win_open
    );

    modport phase (
        input  req,
        input  addr,
        output win_open
    );

endinterface

`default_nettype wire

/* test/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release reset shortly after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_trig_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trig_ctrl;

    localparam int ADDR_W    = 12;
    localparam int WIN_LEN   = 4;
    localparam int WAIT_CLKS = 20;

    logic              sysclk, arst_n, phase, running, pps_trig, event_in;
    logic [ADDR_W-1:0] cur_addr;
    logic [5:0]        gp_in;
    logic              reg_stb, reg_we, reg_ack;
    logic [3:0]        reg_sel;
    logic [7:0]        reg_adr;
    logic [31:0]       reg_wdat, reg_rdat;
    logic [ADDR_W-1:0] soft_addr, pps_addr, ext_addr;
    logic [7:0]        soft_meta, pps_meta, ext_meta;
    logic              soft_valid, pps_valid, ext_valid, mask_update;
    logic [27:0]       trig_mask;
    logic [15:0]       trig_latency, trig_offset, trig_holdoff;

    logic [31:0]       cnt;
    int                ph;
    int                errors;
    int                checks;
    int                nvec;
    bit                test_bad;
    // expected sample address per source and whether one is outstanding
    logic [ADDR_W-1:0] stamp [3];
    bit                armed [3];

    tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(3)) u_clkgen (
        .clk_o  (sysclk),
        .rst_n_o(arst_n)
    );

    trig_ctrl_top #(.ADDR_W(ADDR_W)) dut (
        .sysclk_i(sysclk), .arst_n_i(arst_n), .sysclk_phase_i(phase),
        .cur_addr_i(cur_addr), .running_i(running), .pps_trig_i(pps_trig),
        .gp_in_i(gp_in), .event_i(event_in),
        .reg_stb_i(reg_stb), .reg_we_i(reg_we), .reg_sel_i(reg_sel),
        .reg_adr_i(reg_adr), .reg_wdat_i(reg_wdat),
        .reg_rdat_o(reg_rdat), .reg_ack_o(reg_ack),
        .soft_addr_o(soft_addr), .soft_meta_o(soft_meta), .soft_valid_o(soft_valid),
        .pps_addr_o(pps_addr), .pps_meta_o(pps_meta), .pps_valid_o(pps_valid),
        .ext_addr_o(ext_addr), .ext_meta_o(ext_meta), .ext_valid_o(ext_valid),
        .trig_mask_o(trig_mask), .mask_update_o(mask_update),
        .trig_latency_o(trig_latency), .trig_offset_o(trig_offset),
        .trig_holdoff_o(trig_holdoff)
    );

    // advance one clock with the sample address counting up and a phase strobe every 8 clocks
    task automatic step();
        @(posedge sysclk);
        #10;
        cnt      = cnt + 32'd1;
        cur_addr = cnt[ADDR_W-1:0];
        ph       = (ph + 1) % 8;
        phase    = (ph == 0);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic report(input string what);
        $display("%s", what);
        errors++;
        test_bad = 1'b1;
    endtask

    function automatic string src_name(input int src);
        case (src)
            0:       return "soft";
            1:       return "pps";
            default: return "ext";
        endcase
    endfunction

    function automatic logic valid_of(input int src);
        return (src == 0) ? soft_valid : (src == 1) ? pps_valid : ext_valid;
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(input int src);
        return (src == 0) ? soft_addr : (src == 1) ? pps_addr : ext_addr;
    endfunction

    function automatic logic [7:0] meta_of(input int src);
        return (src == 0) ? soft_meta : (src == 1) ? pps_meta : ext_meta;
    endfunction

    task automatic reg_access(input bit write, input logic [7:0] adr, input logic [31:0] data,
                              input logic [3:0] sel, input logic [31:0] exp);
        step();
        reg_stb  = 1'b1;
        reg_we   = write;
        reg_adr  = adr;
        reg_wdat = data;
        reg_sel  = sel;
        // soft request samples the address one clock after the ack
        if (write && adr == 8'h10 && !armed[0]) begin
            stamp[0] = cnt[ADDR_W-1:0] + ADDR_W'(1);
            armed[0] = 1'b1;
        end
        step();
        reg_stb = 1'b0;
        reg_we  = 1'b0;
        check("reg_ack_o", 32'(reg_ack), 32'd1);
        if (write) begin
            check("mask_update_o", 32'(mask_update), 32'(adr == 8'h00));
        end else begin
            check("reg_rdat_o", reg_rdat, exp);
        end
        step();
        check("reg_ack_o", 32'(reg_ack), 32'd0);
        check("mask_update_o", 32'(mask_update), 32'd0);
    endtask

    task automatic pulse_pps();
        step();
        pps_trig = 1'b1;
        // two sync flops and the edge flop before capture
        if (!armed[1]) begin
            stamp[1] = cnt[ADDR_W-1:0] + ADDR_W'(3);
            armed[1] = 1'b1;
        end
        step();
        step();
        pps_trig = 1'b0;
        step();
    endtask

    task automatic set_gp(input logic [5:0] val);
        step();
        gp_in = val;
        if (val != 6'd0 && !armed[2]) begin
            stamp[2] = cnt[ADDR_W-1:0] + ADDR_W'(3);
            armed[2] = 1'b1;
        end
    endtask

    task automatic expect_trig(input int src, input logic [31:0] ofs, input logic [31:0] meta);
        bit                found;
        int                width;
        logic [ADDR_W-1:0] exp_addr;
        string             name;
        found = 1'b0;
        width = 0;
        name = src_name(src);
        exp_addr = stamp[src] - ofs[ADDR_W-1:0];
        for (int i = 0; i < WAIT_CLKS && !found; i++) begin
            step();
            found = valid_of(src);
        end
        if (!found) begin
            report($sformatf("no trigger from source %0d within %0d clocks", src, WAIT_CLKS));
        end else begin
            check({name, "_addr_o"}, 32'(addr_of(src)), 32'(exp_addr));
            check({name, "_meta_o"}, 32'(meta_of(src)), meta);
            while (valid_of(src) && width <= WIN_LEN + 2) begin
                width++;
                step();
            end
            check({name, "_valid_o width"}, 32'(width), 32'(WIN_LEN));
        end
        armed[src] = 1'b0;
    endtask

    task automatic expect_none(input int src);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_CLKS; i++) begin
            step();
            seen = seen | valid_of(src);
        end
        if (seen) begin
            report($sformatf("source %0d gave a trigger that should not appear", src));
        end
        armed[src] = 1'b0;
    endtask

    task automatic run_vector(input string op, input logic [31:0] a, input logic [31:0] d,
                              input logic [31:0] e);
        case (op)
            "wr":    reg_access(1'b1, a[7:0], d, e[3:0], 32'd0);
            "rd":    reg_access(1'b0, a[7:0], 32'd0, 4'h0, e);
            "pps":   pulse_pps();
            "gpin":  set_gp(d[5:0]);
            "exp":   expect_trig(int'(a), d, e);
            "none":  expect_none(int'(a));
            "idle":  repeat (int'(d)) step();
            "evt": begin
                step();
                event_in = 1'b1;
                step();
                event_in = 1'b0;
            end
            "run": begin
                step();
                running = d[0];
            end
            "align": begin
                // next op then drives one clock after a phase strobe
                step();
                while (ph != 0) step();
            end
            "meta":  check({src_name(int'(a)), "_meta_o"}, 32'(meta_of(int'(a))), e);
            "cfg": begin
                case (a)
                    32'd0:   check("trig_mask_o", 32'(trig_mask), e);
                    32'd1:   check("trig_latency_o", 32'(trig_latency), e);
                    32'd2:   check("trig_offset_o", 32'(trig_offset), e);
                    default: check("trig_holdoff_o", 32'(trig_holdoff), e);
                endcase
            end
            default: report($sformatf("unknown operation %s in vector file", op));
        endcase
    endtask

    initial begin
        int          fd;
        int          nf;
        int          idx;
        string       line;
        string       op;
        logic [31:0] a, d, e;
        cur_addr = '0;
        phase    = 1'b0;
        running  = 1'b0;
        pps_trig = 1'b0;
        gp_in    = '0;
        event_in = 1'b0;
        reg_stb  = 1'b0;
        reg_we   = 1'b0;
        reg_sel  = '0;
        reg_adr  = '0;
        reg_wdat = '0;
        cnt      = '0;
        ph       = 0;
        errors   = 0;
        checks   = 0;
        nvec     = 0;
        idx      = 0;
        for (int i = 0; i < 3; i++) begin
            stamp[i] = '0;
            armed[i] = 1'b0;
        end
        fd = $fopen("test/trig_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            $display("sim failed");
            $finish;
        end else begin
            // first pass only sizes the watchdog
            while (!$feof(fd)) begin
                nf = $fgets(line, fd);
                if (nf > 0) begin
                    nf = $sscanf(line, "%s %h %h %h", op, a, d, e);
                end
                if (nf == 4 && op != "#") begin
                    nvec++;
                end
            end
            $fclose(fd);
            fd = $fopen("test/trig_input.txt", "r");
            @(posedge arst_n);
            step();
            step();
            while (!$feof(fd)) begin
                nf = $fgets(line, fd);
                if (nf > 0) begin
                    nf = $sscanf(line, "%s %h %h %h", op, a, d, e);
                end
                if (nf == 4 && op != "#") begin
                    idx++;
                    test_bad = 1'b0;
                    run_vector(op, a, d, e);
                    $display("test %0d %s %h %h %h: %s", idx, op, a, d, e,
                             test_bad ? "error" : "ok");
                end
            end
            $fclose(fd);
            if (idx == 0) begin
                report("the vector file holds no vectors");
            end
            $display("tests %0d, checks %0d, errors %0d", idx, checks, errors);
            if (errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

    // bound scales with the number of vectors
    initial begin
        wait (nvec > 0);
        repeat (nvec * 40 + 100) @(posedge sysclk);
        $display("watchdog expired before the vectors finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/trig_input.txt */
# columns: op addr_or_src data expected_or_sel, numbers in hex
# wr uses the last column as byte select, exp takes src offset meta
rd 00 0 0fffffff
rd 04 0 0
rd 08 0 0
rd 0c 0 0
rd 10 0 0
rd 18 0 0
rd 1c 0 0
rd 14 0 0
wr 04 12345678 3
rd 04 0 00005678
wr 04 aabbccdd c
rd 04 0 aabb5678
cfg 1 0 5678
cfg 2 0 aabb
wr 00 00000f00 2
rd 00 0 0fff0fff
cfg 0 0 0fff0fff
wr 18 00001234 f
cfg 3 0 1234
run 0 1 0
idle 0 4 0
rd 10 0 00010000
wr 10 0 f
exp 0 0 80
wr 10 0 f
exp 0 0 81
wr 08 00050001 f
align 0 0 0
pps 0 0 0
pps 0 0 0
exp 1 5 80
none 1 0 0
wr 08 00050000 1
rd 08 0 00050000
pps 0 0 0
none 1 0 0
wr 0c 00070301 f
gpin 0 4 0
gpin 0 0 0
exp 2 7 80
wr 0c 00070001 2
gpin 0 3f 0
gpin 0 0 0
none 2 0 0
evt 0 0 0
evt 0 0 0
evt 0 0 0
rd 1c 0 3
run 0 0 0
idle 0 4 0
rd 1c 0 0
meta 0 0 80
meta 1 0 80
meta 2 0 80
